//--- src.f
hdl/adc_spi_pkg.sv
hdl/adc_cmd_pkg.sv
hdl/adc_cmd_sequencer.sv
hdl/spi_frame_tx.sv
hdl/spi_word_rx.sv
hdl/sample_pair_packer.sv
hdl/ads816x_ctrl_top.sv
testbench/ads816x_ctrl_checker.sv
testbench/ads816x_ctrl_tb.sv

//--- Makefile
VERILATOR      ?= verilator
TOP            ?= ads816x_ctrl_tb
TIMEOUT_CYCLES ?= 8000
OBJ_DIR        ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "Variables: VERILATOR TOP TIMEOUT_CYCLES OBJ_DIR"

test:
	$(VERILATOR) --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-GTIMEOUT_CYCLES=$(TIMEOUT_CYCLES) --Mdir $(OBJ_DIR) -f src.f
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/ads816x_ctrl_tb.sv
module ads816x_ctrl_tb #(
  parameter int TIMEOUT_CYCLES = 8000  // 4 reads x 300 plus delays and settle time
);

  timeunit 1ns;
  timeprecision 100ps;

  import adc_spi_pkg::*;
  import adc_cmd_pkg::*;

  logic clk, resetn, cmd_buf_empty, cmd_word_rd_en, trigger, waiting_for_trig;
  logic data_word_wr_en, data_buf_full, setup_done, bad_cmd, cmd_buf_underflow;
  logic data_buf_overflow, unexp_trig, delay_too_short, n_cs, mosi, miso;
  cmd_word_t  cmd_word;
  data_word_t data_word;

  cmd_word_t   cmd_q[$];   // Command buffer model
  data_word_t  exp_q[$];   // Expected data words
  logic        rd_seen;    // Pop seen at the falling edge
  logic [15:0] req_bits;   // Request shifted off MOSI
  logic [15:0] reply;      // Answer for the frame in flight
  int          bit_i;
  int          cycles;
  logic [31:0] seed = 32'h3633;

  ads816x_ctrl_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [15:0] sample_for(input int ch);
    return 16'hA000 + 16'(ch) * 16'h0111;
  endfunction

  function automatic cmd_word_t make_cmd(input logic [2:0] op, input logic trig, input int cnt);
    return {op, trig, 1'b0, 1'b0, 26'(cnt)};  // Bit 26 unused
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
      fail_run("value check failed");
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic apply_reset;
    cmd_q.delete();
    exp_q.delete();
    @(posedge clk);
    #2 resetn = 1'b0;
    wait_cycles(10);
    #2 resetn = 1'b1;
  endtask

  task automatic pulse_trigger;
    @(posedge clk);
    #2 trigger = 1'b1;
    @(posedge clk);
    #2 trigger = 1'b0;
  endtask

  // No frame may open while halted
  task automatic expect_bus_idle(input int n, input string what);
    for (int k = 0; k < n; k++) begin
      @(posedge clk);
      #2 check_eq(n_cs, 1'b1, what);
    end
  endtask

  // Queue a read and the four words its sample order should produce
  task automatic run_read(input int order[8]);
    for (int p = 0; p < 4; p++) begin
      exp_q.push_back({sample_for(order[2*p+1]), sample_for(order[2*p])});
    end
    cmd_q.push_back(make_cmd(CMD_ADC_RD, 1'b0, 400));
    while (exp_q.size() != 0) @(posedge clk);
    wait_cycles(200);  // Let the parallel delay run out
  endtask

  ////////////////////////////////////////////////////////////////////////
  // Command buffer, ADC model, monitors
  ////////////////////////////////////////////////////////////////////////

  always @(negedge clk) rd_seen = cmd_word_rd_en;

  always @(posedge clk) begin
    #2;
    if (rd_seen && cmd_q.size() != 0) void'(cmd_q.pop_front());
    cmd_buf_empty = (cmd_q.size() == 0);
    cmd_word = cmd_buf_empty ? '0 : cmd_q[0];
  end

  // Reply goes out while the next request comes in
  always @(posedge clk) begin
    #2;
    if (!n_cs) begin
      req_bits[15-bit_i] = mosi;
      miso = reply[15-bit_i];
      bit_i++;
    end else begin
      if (bit_i == 16) reply = sample_for(int'(req_bits[13:11]));  // Channel after prefix
      bit_i = 0;
    end
  end

  always @(negedge clk) begin
    if (resetn && data_word_wr_en) begin
      if (exp_q.size() == 0) fail_run("data buffer written when no word was due");
      else begin
        check_eq(data_word, exp_q[0], "data_word");
        void'(exp_q.pop_front());
      end
    end
    if (dut0.chk0.fail_cnt != 0) fail_run("a protocol assertion failed");
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) fail_run("timeout, the DUT stopped making progress");
  end

  ////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////

  initial begin
    int ident[8];
    int rev[8];
    cmd_word_t ord_cmd;
    resetn = 1'b0;
    trigger = 1'b0;
    data_buf_full = 1'b0;
    miso = 1'b0;
    cmd_buf_empty = 1'b1;
    cmd_word = '0;
    rd_seen = 1'b0;
    cycles = 0;
    bit_i = 0;
    reply = '0;
    req_bits = '0;
    for (int i = 0; i < 8; i++) begin
      ident[i] = i;
      rev[i] = 7 - i;
    end
    apply_reset();
    @(posedge clk);
    #2;
    check_eq(n_cs, 1'b1, "n_cs after reset");
    check_eq(setup_done, 1'b1, "setup_done");
    check_eq({bad_cmd, cmd_buf_underflow, data_buf_overflow, unexp_trig, delay_too_short},
             '0, "error flags after reset");
    check_eq({cmd_word_rd_en, data_word_wr_en, waiting_for_trig}, '0, "strobes after reset");
    run_read(ident);                              // Pairs 0,1 / 2,3 / 4,5 / 6,7
    ord_cmd = '0;
    ord_cmd[31:29] = CMD_SET_ORD;
    for (int i = 0; i < 8; i++) ord_cmd[3*i +: 3] = 3'(rev[i]);
    cmd_q.push_back(ord_cmd);
    run_read(rev);                                // Pairs 7,6 / 5,4 / 3,2 / 1,0
    // Trigger wait of three
    cmd_q.push_back(make_cmd(CMD_NO_OP, 1'b1, 3));
    while (!waiting_for_trig) @(posedge clk);
    for (int k = 0; k < 3; k++) begin
      seed = lcg_next(seed);
      wait_cycles(1 + int'(seed[17:16]));
      pulse_trigger();
      check_eq(waiting_for_trig, (k < 2), "waiting_for_trig");
    end
    // Cancel a long delay, then a short one must go through
    cmd_q.push_back(make_cmd(CMD_NO_OP, 1'b0, 100000));
    wait_cycles(5);
    cmd_q.push_back(make_cmd(CMD_CANCEL, 1'b0, 0));
    cmd_q.push_back(make_cmd(CMD_NO_OP, 1'b0, 5));
    while (cmd_q.size() != 0) @(posedge clk);
    wait_cycles(10);
    #2 check_eq({bad_cmd, cmd_buf_underflow, unexp_trig, delay_too_short}, '0,
                "flags after cancel");
    // Error cases, a read queued behind the fault must not open a frame
    cmd_q.push_back({3'b001, 29'd0});
    cmd_q.push_back(make_cmd(CMD_ADC_RD, 1'b0, 400));
    while (!bad_cmd) @(posedge clk);
    expect_bus_idle(50, "n_cs after bad_cmd");
    apply_reset();
    check_eq(bad_cmd, 1'b0, "bad_cmd after reset");
    pulse_trigger();
    while (!unexp_trig) @(posedge clk);
    cmd_q.push_back(make_cmd(CMD_ADC_RD, 1'b0, 400));
    expect_bus_idle(50, "n_cs after unexp_trig");
    apply_reset();
    check_eq(unexp_trig, 1'b0, "unexp_trig after reset");
    cmd_q.push_back(make_cmd(CMD_ADC_RD, 1'b0, 10));
    while (!delay_too_short) @(posedge clk);
    wait_cycles(40);                               // Frame in flight finishes
    expect_bus_idle(100, "n_cs after delay_too_short");
    apply_reset();
    check_eq(delay_too_short, 1'b0, "delay_too_short after reset");
    // Full data buffer during a read
    data_buf_full = 1'b1;
    cmd_q.push_back(make_cmd(CMD_ADC_RD, 1'b0, 400));
    while (!data_buf_overflow) @(posedge clk);
    wait_cycles(100);
    apply_reset();
    data_buf_full = 1'b0;
    check_eq(data_buf_overflow, 1'b0, "data_buf_overflow after reset");
    wait_cycles(5);
    if (dut0.chk0.fail_cnt != 0) begin
      fail_run("a protocol assertion failed");
    end else begin
      $display("All tests passed");
      $finish;
    end
  end

endmodule

//--- testbench/ads816x_ctrl_checker.sv
module ads816x_ctrl_checker (
  input logic clk,
  input logic resetn,
  input logic n_cs,
  input logic frame_start,
  input logic frame_done,
  input logic word_valid,
  input logic data_word_wr_en
);

  timeunit 1ns;
  timeprecision 100ps;

  import adc_spi_pkg::*;

  int fail_cnt = 0;  // Read by the testbench

  //////////////////////////////////////////////////////////////////////
  // Chip select timing
  //////////////////////////////////////////////////////////////////////

  // Conversion gap between frames
  a_cs_gap: assert property (@(posedge clk) disable iff (!resetn)
    $rose(n_cs) |-> n_cs [*N_CS_HIGH_CYCLES])
    else begin $error("n_cs high gap too short"); fail_cnt++; end

  a_cs_low: assert property (@(posedge clk) disable iff (!resetn)
    $fell(n_cs) |-> !n_cs [*OTF_FRAME_BITS] ##1 n_cs)  // Exactly one frame of bits
    else begin $error("n_cs low time not 16 cycles"); fail_cnt++; end

  a_start_fall: assert property (@(posedge clk) disable iff (!resetn)
    frame_start |-> ##N_CS_HIGH_CYCLES $fell(n_cs))
    else begin $error("n_cs did not fall on time after frame_start"); fail_cnt++; end

  //////////////////////////////////////////////////////////////////////
  // Strobes
  //////////////////////////////////////////////////////////////////////

  a_fs_pulse: assert property (@(posedge clk) disable iff (!resetn)
    frame_start |=> !frame_start)
    else begin $error("frame_start longer than one cycle"); fail_cnt++; end

  // Captured word lands in the cycle the framer closes the frame
  a_wv_done: assert property (@(posedge clk) disable iff (!resetn)
    word_valid == frame_done)
    else begin $error("word_valid not aligned with frame_done"); fail_cnt++; end

  a_wr_pulse: assert property (@(posedge clk) disable iff (!resetn)
    data_word_wr_en |=> !data_word_wr_en)
    else begin $error("data_word_wr_en longer than one cycle"); fail_cnt++; end

endmodule

bind ads816x_ctrl_top ads816x_ctrl_checker chk0 (.*);

//--- hdl/ads816x_ctrl_top.sv
module ads816x_ctrl_top (
  input  logic                    clk,
  input  logic                    resetn,
  input  adc_cmd_pkg::cmd_word_t  cmd_word,
  input  logic                    cmd_buf_empty,
  output logic                    cmd_word_rd_en,
  input  logic                    trigger,
  output logic                    waiting_for_trig,
  output adc_cmd_pkg::data_word_t data_word,
  output logic                    data_word_wr_en,
  input  logic                    data_buf_full,
  output logic                    setup_done,
  output logic                    bad_cmd,
  output logic                    cmd_buf_underflow,
  output logic                    data_buf_overflow,
  output logic                    unexp_trig,
  output logic                    delay_too_short,
  output logic                    n_cs,
  output logic                    mosi,
  input  logic                    miso
);

  import adc_spi_pkg::*;

  logic         frame_start;
  logic         frame_done;
  adc_channel_t frame_channel;
  logic         read_start;
  adc_sample_t  word;
  logic         word_valid;

  // Command side, owns four of the five flags
  adc_cmd_sequencer seq0 (
    .clk, .resetn, .cmd_word, .cmd_buf_empty, .trigger, .frame_done,
    .halt (data_buf_overflow),  // Packer overflow stops the sequencer too
    .cmd_word_rd_en, .frame_start, .frame_channel, .read_start, .waiting_for_trig,
    .setup_done, .bad_cmd, .cmd_buf_underflow, .unexp_trig, .delay_too_short
  );

  // MOSI framing
  spi_frame_tx tx0 (
    .clk, .resetn, .frame_start, .frame_channel, .n_cs, .mosi, .frame_done
  );

  // MISO capture, reply belongs to the previous frame
  spi_word_rx rx0 (
    .clk, .resetn, .n_cs, .miso, .word, .word_valid
  );

  sample_pair_packer pack0 (
    .clk, .resetn, .read_start, .word, .word_valid, .data_buf_full,
    .data_word, .data_word_wr_en, .data_buf_overflow
  );

endmodule

//--- hdl/sample_pair_packer.sv
module sample_pair_packer (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     read_start,
  input  adc_spi_pkg::adc_sample_t word,
  input  logic                     word_valid,
  input  logic                     data_buf_full,
  output adc_cmd_pkg::data_word_t  data_word,
  output logic                     data_word_wr_en,
  output logic                     data_buf_overflow
);

  import adc_spi_pkg::*;

  adc_sample_t low_sample;  // Earlier sample of the pair
  logic        skip_word;   // Next word is the stale reply from before the read
  logic        have_low;    // low_sample holds a sample
  logic        pair_ready;  // Full pair in data_word

  always_ff @(posedge clk) begin
    if (!resetn) begin
      skip_word  <= 1'b0;
      have_low   <= 1'b0;
      pair_ready <= 1'b0;
    end else begin
      pair_ready <= 1'b0;
      if (read_start) begin
        skip_word <= 1'b1;
        have_low  <= 1'b0;
      end else if (word_valid) begin
        if (skip_word) begin
          skip_word <= 1'b0;        // Drop it
        end else begin
          have_low   <= !have_low;
          pair_ready <= have_low;   // Second of two
        end
      end
    end
  end

  // Pair assembly
  always_ff @(posedge clk) begin
    if (word_valid && !skip_word) begin
      if (have_low) data_word <= {word, low_sample};  // Later sample on top
      else low_sample <= word;
    end
  end

  // Full buffer at write time is an overflow, the pair is lost
  assign data_word_wr_en = pair_ready && !data_buf_full && !data_buf_overflow;

  always_ff @(posedge clk) begin
    if (!resetn) data_buf_overflow <= 1'b0;
    else if (pair_ready && data_buf_full) data_buf_overflow <= 1'b1;
  end

endmodule

//--- hdl/spi_word_rx.sv
module spi_word_rx (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic                     n_cs,
  input  logic                     miso,
  output adc_spi_pkg::adc_sample_t word,
  output logic                     word_valid
);

  import adc_spi_pkg::*;

  logic n_cs_q;  // Chip select one clock back

  //////////////////////////////////////////////////////////////////////
  // MISO capture
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      n_cs_q <= 1'b1;  // Bus idle, no false edge out of reset
    end else begin
      n_cs_q <= n_cs;
    end
  end

  // One bit per low cycle, MSB arrives first
  always_ff @(posedge clk) begin
    if (!n_cs) begin
      word <= {word[OTF_FRAME_BITS-2:0], miso};
    end
  end

  // Word complete on the cycle chip select comes back high
  assign word_valid = n_cs && !n_cs_q;

endmodule

//--- hdl/spi_frame_tx.sv
module spi_frame_tx (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic                      frame_start,
  input  adc_spi_pkg::adc_channel_t frame_channel,
  output logic                      n_cs,
  output logic                      mosi,
  output logic                      frame_done
);

  import adc_spi_pkg::*;

  logic [$clog2(N_CS_HIGH_CYCLES)-1:0] cs_timer;   // Conversion gap countdown
  logic                                cs_wait;    // Gap running
  logic [$clog2(OTF_FRAME_BITS)-1:0]   bit_cnt;    // Bits left in the frame
  adc_sample_t                         req_shift;  // Request, MSB on the wire

  // Chip select sequencing
  // n_cs falls N_CS_HIGH_CYCLES after the frame_start cycle, stays low 16 clocks
  always_ff @(posedge clk) begin
    if (!resetn) begin
      cs_wait    <= 1'b0;
      cs_timer   <= '0;
      n_cs       <= 1'b1;
      bit_cnt    <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= 1'b0;
      if (frame_start) begin
        cs_wait  <= 1'b1;
        cs_timer <= $bits(cs_timer)'(N_CS_HIGH_CYCLES - 2);  // Start cycle plus load edge
      end else if (cs_wait) begin
        if (cs_timer == '0) begin
          cs_wait <= 1'b0;
          n_cs    <= 1'b0;                                   // Open the frame
          bit_cnt <= $bits(bit_cnt)'(OTF_FRAME_BITS - 1);
        end else begin
          cs_timer <= cs_timer - 1'b1;
        end
      end else if (!n_cs) begin
        if (bit_cnt == '0) begin
          n_cs       <= 1'b1;                                // Close, conversion starts
          frame_done <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt - 1'b1;
        end
      end
    end
  end

  // Request shift register
  always_ff @(posedge clk) begin
    if (!resetn) begin
      req_shift <= '0;
    end else if (frame_start) begin
      req_shift <= {OTF_REQ_PREFIX, frame_channel,
                    {(OTF_FRAME_BITS - $bits(OTF_REQ_PREFIX) - $bits(adc_channel_t)){1'b0}}};
    end else if (!n_cs) begin
      req_shift <= {req_shift[OTF_FRAME_BITS-2:0], 1'b0};   // Next bit each low cycle
    end
  end

  assign mosi = req_shift[OTF_FRAME_BITS-1];

endmodule

//--- hdl/adc_cmd_sequencer.sv
module adc_cmd_sequencer (
  input  logic                      clk,
  input  logic                      resetn,
  input  adc_cmd_pkg::cmd_word_t    cmd_word,
  input  logic                      cmd_buf_empty,
  input  logic                      trigger,
  input  logic                      frame_done,
  input  logic                      halt,
  output logic                      cmd_word_rd_en,
  output logic                      frame_start,
  output adc_spi_pkg::adc_channel_t frame_channel,
  output logic                      read_start,
  output logic                      waiting_for_trig,
  output logic                      setup_done,
  output logic                      bad_cmd,
  output logic                      cmd_buf_underflow,
  output logic                      unexp_trig,
  output logic                      delay_too_short
);

  import adc_spi_pkg::*;
  import adc_cmd_pkg::*;

  seq_state_t             state;
  seq_state_t             cmd_state;     // Where the queued command leads
  cmd_op_t                op;
  logic [COUNT_WIDTH-1:0] cmd_field;
  logic [COUNT_WIDTH-1:0] delay_cnt;
  logic [COUNT_WIDTH-1:0] trig_cnt;
  logic                   wait_trig;     // Latched TRIG_BIT of the running command
  logic                   expect_next;   // Latched CONT_BIT
  adc_channel_t           sample_order [N_CHANNELS];
  logic [3:0]             frame_idx;     // Frames issued in this read
  logic known_op, cmd_done, accept, accept_read, loads_wait, cancel_wait;
  logic trig_hit, delay_hit, wait_hit, last_frame, next_frame, read_fin;
  logic bad_evt, underflow_evt, delay_evt, unexp_evt, fault;

  //////////////////////////////////////////////////////////////////////
  // Command decode and completion
  //////////////////////////////////////////////////////////////////////

  assign op        = cmd_op_t'(cmd_word[CMD_OP_MSB:CMD_OP_LSB]);
  assign cmd_field = cmd_word[COUNT_WIDTH-1:0];

  assign trig_hit   = (trig_cnt == '0) || (trigger && trig_cnt == COUNT_WIDTH'(1)); // Last trigger
  assign delay_hit  = (delay_cnt == '0);
  assign wait_hit   = wait_trig ? trig_hit : delay_hit;
  assign last_frame = (frame_idx == 4'(N_CHANNELS + 1));  // Extra frame clocks out the last reply
  assign next_frame = (state == S_ADC_RD) && frame_done && !last_frame;
  assign read_fin   = (state == S_ADC_RD) && frame_done && last_frame;

  always_comb begin
    case (state)
      S_IDLE:               cmd_done = !cmd_buf_empty;
      S_DELAY, S_TRIG_WAIT: cmd_done = wait_hit;
      S_ADC_RD:             cmd_done = read_fin && wait_hit;  // Read and wait both over
      default:              cmd_done = 1'b0;
    endcase
  end

  always_comb begin
    known_op = 1'b1;
    case (op)
      CMD_NO_OP:   cmd_state = cmd_word[TRIG_BIT] ? S_TRIG_WAIT : S_DELAY;
      CMD_ADC_RD:  cmd_state = S_ADC_RD;
      CMD_SET_ORD,
      CMD_CANCEL:  cmd_state = S_IDLE;
      default: begin
        cmd_state = S_ERROR;
        known_op  = 1'b0;
      end
    endcase
  end

  assign accept      = cmd_done && !cmd_buf_empty;
  assign accept_read = accept && (op == CMD_ADC_RD);
  assign loads_wait  = accept && (op == CMD_NO_OP || op == CMD_ADC_RD);
  // Cancel may jump the queue while a wait is pending
  assign cancel_wait = (state == S_DELAY || state == S_TRIG_WAIT)
                       && !cmd_buf_empty && (op == CMD_CANCEL);
  assign cmd_word_rd_en   = accept || cancel_wait;
  assign waiting_for_trig = (state == S_TRIG_WAIT);

  // Error events
  assign bad_evt       = accept && !known_op;
  assign underflow_evt = cmd_done && cmd_buf_empty && expect_next;
  assign delay_evt     = (state == S_ADC_RD) && !read_fin && !wait_trig && delay_hit;
  assign unexp_evt     = (state != S_TRIG_WAIT) && (state != S_ERROR)
                         && trigger && (trig_cnt == '0);
  assign fault = bad_evt || underflow_evt || delay_evt || unexp_evt || halt;

  always_ff @(posedge clk) begin
    if (!resetn) state <= S_IDLE;
    else if (fault) state <= S_ERROR;              // Stuck here until reset
    else if (cancel_wait) state <= S_IDLE;
    else if (accept) state <= cmd_state;
    else if (cmd_done) state <= S_IDLE;            // Finished, nothing queued
    else if (read_fin) state <= wait_trig ? S_TRIG_WAIT : S_DELAY;  // Wait outlasts read
  end

  always_ff @(posedge clk) begin
    if (!resetn || cancel_wait) begin
      wait_trig   <= 1'b0;
      expect_next <= 1'b0;
    end else if (accept) begin
      wait_trig   <= loads_wait && cmd_word[TRIG_BIT];
      expect_next <= loads_wait && cmd_word[CONT_BIT];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Delay and trigger counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn || cancel_wait || state == S_ERROR) begin
      delay_cnt <= '0;
      trig_cnt  <= '0;
    end else if (loads_wait) begin
      delay_cnt <= cmd_word[TRIG_BIT] ? '0 : cmd_field;
      trig_cnt  <= cmd_word[TRIG_BIT] ? cmd_field : '0;
    end else begin
      if (!delay_hit) delay_cnt <= delay_cnt - 1'b1;                 // Every clock
      if (trigger && trig_cnt != '0) trig_cnt <= trig_cnt - 1'b1;    // Per trigger
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sample order and frame scheduling
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < N_CHANNELS; i++) sample_order[i] <= adc_channel_t'(i); // Identity
    end else if (accept && op == CMD_SET_ORD) begin
      for (int i = 0; i < N_CHANNELS; i++) begin
        sample_order[i] <= cmd_word[$bits(adc_channel_t)*i +: $bits(adc_channel_t)];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      frame_idx   <= '0;
      frame_start <= 1'b0;
      read_start  <= 1'b0;
      setup_done  <= 1'b0;
    end else begin
      setup_done  <= 1'b1;
      frame_start <= (accept_read || next_frame) && !fault;  // A cycle after frame_done
      read_start  <= accept_read && !fault;
      if (accept_read) frame_idx <= 4'd1;
      else if (next_frame) frame_idx <= frame_idx + 1'b1;
    end
  end

  // Channel for the frame about to start, filler channel 0 on the last one
  always_ff @(posedge clk) begin
    if (accept_read) begin
      frame_channel <= sample_order[0];
    end else if (next_frame) begin
      frame_channel <= (frame_idx < 4'(N_CHANNELS)) ? sample_order[adc_channel_t'(frame_idx)]
                                                    : '0;
    end
  end

  // Sticky flags
  always_ff @(posedge clk) begin
    if (!resetn) begin
      bad_cmd           <= 1'b0;
      cmd_buf_underflow <= 1'b0;
      unexp_trig        <= 1'b0;
      delay_too_short   <= 1'b0;
    end else begin
      if (bad_evt)       bad_cmd           <= 1'b1;
      if (underflow_evt) cmd_buf_underflow <= 1'b1;
      if (unexp_evt)     unexp_trig        <= 1'b1;
      if (delay_evt)     delay_too_short   <= 1'b1;
    end
  end

endmodule

//--- hdl/adc_cmd_pkg.sv
package adc_cmd_pkg;

  //////////////////////////////////////////////////////////////////////
  // Command word layout
  //////////////////////////////////////////////////////////////////////

  localparam int CMD_OP_MSB  = 31;  // Opcode field top
  localparam int CMD_OP_LSB  = 29;  // Opcode field bottom
  localparam int TRIG_BIT    = 28;  // Wait counts triggers instead of clocks
  localparam int CONT_BIT    = 27;  // Another command must follow
  localparam int COUNT_WIDTH = 26;  // Delay or trigger count in the low bits

  // Opcodes, any other code is rejected
  typedef enum logic [2:0] {
    CMD_NO_OP   = 3'b000,  // Wait only
    CMD_ADC_RD  = 3'b010,  // Read all channels once, wait in parallel
    CMD_SET_ORD = 3'b100,  // Load sample order, 3 bits per slot
    CMD_CANCEL  = 3'b111   // Drop a pending wait
  } cmd_op_t;

  //////////////////////////////////////////////////////////////////////
  // Sequencer states
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    S_IDLE,
    S_DELAY,      // Counting clocks
    S_TRIG_WAIT,  // Counting triggers
    S_ADC_RD,     // Nine frames on the bus
    S_ERROR       // Halted until reset
  } seq_state_t;

  typedef logic [31:0] cmd_word_t;   // From the command buffer
  typedef logic [31:0] data_word_t;  // Two samples, earlier one low

endpackage

//--- hdl/adc_spi_pkg.sv
package adc_spi_pkg;

  //////////////////////////////////////////////////////////////////////
  // ADS8168 conversion timing
  //////////////////////////////////////////////////////////////////////

  localparam int T_CONV_NS  = 660;         // Conversion time
  localparam int T_CYCLE_NS = 1000;        // Minimum throughput period
  localparam int SPI_CLK_HZ = 20_000_000;  // Bit clock, also the system clock

  // Round up to whole clocks, clock taken in MHz so the product fits an int
  localparam int N_CONV_CYCLES  = (T_CONV_NS * (SPI_CLK_HZ / 1_000_000) + 999) / 1000;
  localparam int N_CYCLE_CYCLES = (T_CYCLE_NS * (SPI_CLK_HZ / 1_000_000) + 999) / 1000;

  localparam int OTF_FRAME_BITS = 16;  // One on-the-fly request per frame

  // Longer of conversion time and what is left of the cycle after the frame
  localparam int N_CS_MIN_GAP =
    (N_CONV_CYCLES > N_CYCLE_CYCLES - OTF_FRAME_BITS) ? N_CONV_CYCLES
                                                      : N_CYCLE_CYCLES - OTF_FRAME_BITS;
  // Chip select high time between frames, never under 3 clocks
  localparam int N_CS_HIGH_CYCLES = (N_CS_MIN_GAP > 3) ? N_CS_MIN_GAP : 3;

  //////////////////////////////////////////////////////////////////////
  // Channels and frame format
  //////////////////////////////////////////////////////////////////////

  localparam int N_CHANNELS = 8;

  // On-the-fly sample request, goes ahead of the channel number
  localparam logic [1:0] OTF_REQ_PREFIX = 2'b10;

  typedef logic [OTF_FRAME_BITS-1:0]    adc_sample_t;   // One MISO word
  typedef logic [$clog2(N_CHANNELS)-1:0] adc_channel_t; // Channel number

endpackage
